//--- Bender.yml
package:
  name: ldstr_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lc3b_types.sv
      - rtl/ldstr_decoder.sv
      - rtl/ldstr_res_station.sv
      - rtl/ldstr_buffer.sv
      - rtl/data_memory.sv
      - rtl/ldstr_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/tb_clock_gen.sv
      - sim/ldstr_unit_tb.sv

//--- compile.f
+incdir+rtl
rtl/lc3b_types.sv
rtl/ldstr_decoder.sv
rtl/ldstr_res_station.sv
rtl/ldstr_buffer.sv
rtl/data_memory.sv
rtl/ldstr_unit.sv
sim/tb_clock_gen.sv
sim/ldstr_unit_tb.sv

//--- rtl/data_memory.sv
`timescale 1ns/100ps
`include "lc3b_defines.svh"

module data_memory import lc3b_types::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     read,
	input  logic     write,
	input  lc3b_word addr,
	input  lc3b_word wdata,
	output logic     resp,
	output lc3b_word rdata
);

localparam int AW = $clog2(`DMEM_WORDS);
localparam int CNT_W = $clog2(`DMEM_LATENCY + 1);

lc3b_word mem [`DMEM_WORDS];
logic [CNT_W-1:0] cnt;
logic [AW-1:0] acc_idx;
lc3b_word acc_wdata;
logic acc_write;
logic active;
logic start;
logic fire;

// No new access in the response cycle while the strobe is still up
assign start = !active && !resp && (read || write);
assign fire = active && cnt == '0;

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		active <= 1'b0;
		cnt <= '0;
		resp <= 1'b0;
	end
	else
	begin
		resp <= fire;
		if (start)
		begin
			active <= 1'b1;
			cnt <= CNT_W'(`DMEM_LATENCY - 1);
		end
		else if (fire)
			active <= 1'b0;
		else if (active)
			cnt <= cnt - 1'b1;
	end
end

// Access is latched at start, so a dropped strobe still completes
always_ff @(posedge clk)
begin
	if (start)
	begin
		acc_idx <= addr[AW:1];
		acc_write <= write;
		acc_wdata <= wdata;
	end
	if (fire)
		rdata <= mem[acc_idx];
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		for (int j = 0; j < `DMEM_WORDS; j++)
			mem[j] <= '0;
	end
	else if (fire && acc_write)
		mem[acc_idx] <= acc_wdata;
end

endmodule

//--- rtl/lc3b_defines.svh
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// Datapath widths
`define LC3B_WORD_W 16
`define LC3B_TAG_W 3

// Load/store buffer
`define LDSTR_DEPTH 8

// Data memory model
// Latency counts cycles from the edge that sees the strobe to the response
`define DMEM_LATENCY 2
`define DMEM_WORDS 256

`endif

//--- rtl/lc3b_types.sv
`include "lc3b_defines.svh"

package lc3b_types;

typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
typedef logic [`LC3B_TAG_W-1:0] lc3b_tag;

typedef enum logic {
	op_ldr,
	op_str
} lc3b_opcode;

// One broadcast on the common data bus
typedef struct packed {
	logic     valid;
	lc3b_tag  tag;
	lc3b_word value;
} cdb_t;

// Dispatched load or store with the offset already sign-extended and scaled
typedef struct packed {
	lc3b_opcode opcode;
	lc3b_tag    dest;
	lc3b_word   base;
	logic       base_valid;
	lc3b_tag    base_tag;
	lc3b_word   src;
	logic       src_valid;
	lc3b_tag    src_tag;
	lc3b_word   offset;
} ldstr_issue_t;

typedef enum logic [2:0] {
	idle,
	wait_opnd,
	ready,
	mem_wait,
	done
} res_state_t;

endpackage

//--- rtl/ldstr_buffer.sv
`timescale 1ns/100ps
`include "lc3b_defines.svh"

module ldstr_buffer import lc3b_types::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         flush,
	input  logic         we,
	input  ldstr_issue_t issue,
	input  logic         ld_buffer_read,
	input  cdb_t         cdb_in,
	input  logic         dmem_resp,
	input  lc3b_word     dmem_rdata,
	output logic         dmem_read,
	output logic         dmem_write,
	output lc3b_word     dmem_addr,
	output lc3b_word     dmem_wdata,
	output logic         full,
	output cdb_t         cdb_out
);

logic [`LDSTR_DEPTH-1:0] alloc_onehot;
logic [`LDSTR_DEPTH-1:0] free_onehot;
logic [`LDSTR_DEPTH-1:0] busy_vec;
logic [`LDSTR_DEPTH-1:0] st_read;
logic [`LDSTR_DEPTH-1:0] st_write;
lc3b_word st_addr [`LDSTR_DEPTH];
lc3b_word st_wdata [`LDSTR_DEPTH];
cdb_t st_result [`LDSTR_DEPTH];
lc3b_tag head;
logic retire;
logic head_resp;
logic stale_resp;

ldstr_decoder u_decoder (
	.clk,
	.arst_n,
	.flush,
	.we,
	.retire,
	.alloc_onehot,
	.free_onehot,
	.head,
	.full
);

// ********************************************************************
// Reservation stations
// ********************************************************************

genvar i;
generate
	for (i = 0; i < `LDSTR_DEPTH; i++)
	begin : g_rs
		ldstr_res_station u_rs (
			.clk,
			.arst_n,
			.clear(flush | free_onehot[i]),
			.alloc(alloc_onehot[i]),
			.issue,
			.cdb_in,
			.at_head(head == lc3b_tag'(i)),
			.dmem_resp(head_resp && head == lc3b_tag'(i)),
			.dmem_rdata,
			.mem_read(st_read[i]),
			.mem_write(st_write[i]),
			.mem_addr(st_addr[i]),
			.mem_wdata(st_wdata[i]),
			.result(st_result[i]),
			.busy(busy_vec[i])
		);
	end
endgenerate

// ********************************************************************
// Head select
// ********************************************************************

// Hold off memory until the answer to an access cut by flush has passed
assign dmem_read = st_read[head] && !stale_resp;
assign dmem_write = st_write[head] && !stale_resp;
assign dmem_addr = st_addr[head];
assign dmem_wdata = st_wdata[head];
assign cdb_out = st_result[head];

assign head_resp = dmem_resp && !stale_resp;
assign retire = (head_resp && st_write[head]) || (ld_buffer_read && st_result[head].valid);

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		stale_resp <= 1'b0;
	else if (flush && (dmem_read || dmem_write) && !dmem_resp)
		stale_resp <= 1'b1;
	else if (dmem_resp)
		stale_resp <= 1'b0;
end

a_no_issue_when_full: assert property (@(posedge clk) disable iff (!arst_n)
	we |-> !full);

// Tail must never wrap onto a live entry
a_alloc_free_entry: assert property (@(posedge clk) disable iff (!arst_n)
	(alloc_onehot & busy_vec) == '0);

endmodule

//--- rtl/ldstr_decoder.sv
`timescale 1ns/100ps
`include "lc3b_defines.svh"

module ldstr_decoder import lc3b_types::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    we,
	input  logic                    retire,
	output logic [`LDSTR_DEPTH-1:0] alloc_onehot,
	output logic [`LDSTR_DEPTH-1:0] free_onehot,
	output lc3b_tag                 head,
	output logic                    full
);

localparam int CNT_W = $clog2(`LDSTR_DEPTH + 1);
localparam lc3b_tag LAST = lc3b_tag'(`LDSTR_DEPTH - 1);

lc3b_tag tail;
logic [CNT_W-1:0] count;
logic do_alloc;

// Issue is dropped during a flush cycle
assign do_alloc = we && !full && !flush;
assign full = (count == CNT_W'(`LDSTR_DEPTH));

always_comb
begin
	alloc_onehot = '0;
	free_onehot = '0;
	if (do_alloc)
		alloc_onehot[tail] = 1'b1;
	if (retire)
		free_onehot[head] = 1'b1;
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		tail <= '0;
		head <= '0;
		count <= '0;
	end
	else if (flush)
	begin
		tail <= '0;
		head <= '0;
		count <= '0;
	end
	else
	begin
		if (do_alloc)
			tail <= (tail == LAST) ? '0 : tail + 1'b1;
		if (retire)
			head <= (head == LAST) ? '0 : head + 1'b1;
		count <= count + CNT_W'(do_alloc) - CNT_W'(retire);
	end
end

a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
	count <= CNT_W'(`LDSTR_DEPTH));

endmodule

//--- rtl/ldstr_res_station.sv
`timescale 1ns/100ps

module ldstr_res_station import lc3b_types::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         clear,
	input  logic         alloc,
	input  ldstr_issue_t issue,
	input  cdb_t         cdb_in,
	input  logic         at_head,
	input  logic         dmem_resp,
	input  lc3b_word     dmem_rdata,
	output logic         mem_read,
	output logic         mem_write,
	output lc3b_word     mem_addr,
	output lc3b_word     mem_wdata,
	output cdb_t         result,
	output logic         busy
);

res_state_t state;
ldstr_issue_t ent;
ldstr_issue_t snoop;
lc3b_word ld_data;
logic take;
logic opnd_ok;
logic mem_phase;

assign take = (state == idle) && alloc;

// ********************************************************************
// Operand capture including the allocating cycle
// ********************************************************************

always_comb
begin
	snoop = take ? issue : ent;
	if (!snoop.base_valid && cdb_in.valid && cdb_in.tag == snoop.base_tag)
	begin
		snoop.base = cdb_in.value;
		snoop.base_valid = 1'b1;
	end
	if (!snoop.src_valid && cdb_in.valid && cdb_in.tag == snoop.src_tag)
	begin
		snoop.src = cdb_in.value;
		snoop.src_valid = 1'b1;
	end
	// Loads never need the source operand
	opnd_ok = snoop.base_valid && (snoop.opcode == op_ldr || snoop.src_valid);
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		state <= idle;
	else if (clear)
		state <= idle;
	else
	begin
		case (state)
			idle:      if (alloc) state <= opnd_ok ? ready : wait_opnd;
			wait_opnd: if (opnd_ok) state <= ready;
			ready:     if (at_head) state <= mem_wait;
			mem_wait:  if (dmem_resp) state <= (ent.opcode == op_ldr) ? done : idle;
			done:      state <= done;
			default:   state <= idle;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (take || state == wait_opnd)
		ent <= snoop;
	if (state == mem_wait && dmem_resp)
		ld_data <= dmem_rdata;
end

// ********************************************************************
// Memory side and result
// ********************************************************************

assign mem_phase = at_head && (state == ready || state == mem_wait);
assign mem_read = mem_phase && ent.opcode == op_ldr;
assign mem_write = mem_phase && ent.opcode == op_str;
assign mem_addr = ent.base + ent.offset;
assign mem_wdata = ent.src;
assign busy = (state != idle);

always_comb
begin
	result.valid = (state == done);
	result.tag = ent.dest;
	result.value = ld_data;
end

a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
	!(mem_read && mem_write));

// An access in flight must keep the head until memory answers
a_wait_at_head: assert property (@(posedge clk) disable iff (!arst_n)
	state == mem_wait |-> at_head);

endmodule

//--- rtl/ldstr_unit.sv
`timescale 1ns/100ps

module ldstr_unit import lc3b_types::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         flush,
	input  logic         we,
	input  ldstr_issue_t issue,
	input  logic         ld_buffer_read,
	input  cdb_t         cdb_in,
	output logic         full,
	output cdb_t         cdb_out
);

logic dmem_read;
logic dmem_write;
logic dmem_resp;
lc3b_word dmem_addr;
lc3b_word dmem_wdata;
lc3b_word dmem_rdata;

ldstr_buffer u_ldstr_buffer (
	.clk,
	.arst_n,
	.flush,
	.we,
	.issue,
	.ld_buffer_read,
	.cdb_in,
	.dmem_resp,
	.dmem_rdata,
	.dmem_read,
	.dmem_write,
	.dmem_addr,
	.dmem_wdata,
	.full,
	.cdb_out
);

data_memory u_data_memory (
	.clk,
	.arst_n,
	.read(dmem_read),
	.write(dmem_write),
	.addr(dmem_addr),
	.wdata(dmem_wdata),
	.resp(dmem_resp),
	.rdata(dmem_rdata)
);

endmodule

//--- sim/ldstr_unit_tb.sv
`timescale 1ns/100ps
`include "lc3b_defines.svh"

module ldstr_unit_tb import lc3b_types::*;
();

localparam int LOAD_WAIT = 30;
localparam int QUIET_CYCLES = 20;
// Cycle budgets of the tests add up to the run limit
localparam int T_RESET = 20;
localparam int T_STORE_LOAD = 40;
localparam int T_OPND = 50;
localparam int T_ORDER = 90;
localparam int T_FULL = 110;
localparam int T_FLUSH = 60;
localparam int CYCLE_LIMIT = T_RESET + T_STORE_LOAD + T_OPND + T_ORDER + T_FULL + T_FLUSH + 30;

logic clk;
logic arst_n;
logic flush;
logic we;
logic ld_buffer_read;
logic full;
ldstr_issue_t issue;
cdb_t cdb_in;
cdb_t cdb_out;

integer seed;
int errors;
int cycles;
lc3b_word shadow [`DMEM_WORDS];
lc3b_word ord_addr [4];

tb_clock_gen u_clock_gen (
	.clk,
	.arst_n
);

ldstr_unit u_ldstr_unit (
	.clk,
	.arst_n,
	.flush,
	.we,
	.issue,
	.ld_buffer_read,
	.cdb_in,
	.full,
	.cdb_out
);

// **********************************************************************
// Helpers
// **********************************************************************

task automatic step();
	@(posedge clk);
	#2;
endtask

task automatic check_val(input string name, input string what, input lc3b_word exp,
	input lc3b_word act);
	assert (act === exp)
	else
	begin
		errors++;
		$display("[FAIL] %s: %s expected %h actual %h", name, what, exp, act);
	end
endtask

function automatic int word_index(input lc3b_word addr);
	return (addr / 2) % `DMEM_WORDS;
endfunction

function automatic lc3b_word rand_addr();
	return lc3b_word'(({$random(seed)} % `DMEM_WORDS) * 2);
endfunction

// Signed and word scaled
function automatic lc3b_word rand_offset();
	return lc3b_word'(($random(seed) % 8) * 2);
endfunction

function automatic ldstr_issue_t make_load(input lc3b_tag dest, input lc3b_word base,
	input logic base_valid, input lc3b_tag base_tag, input lc3b_word offset);
	ldstr_issue_t ins;
	ins = '0;
	ins.opcode = op_ldr;
	ins.dest = dest;
	ins.base = base;
	ins.base_valid = base_valid;
	ins.base_tag = base_tag;
	ins.src_valid = 1'b1;
	ins.offset = offset;
	return ins;
endfunction

// The core gates the write strobe with full
task automatic issue_op(input ldstr_issue_t ins);
	while (full)
		step();
	we = 1'b1;
	issue = ins;
	step();
	we = 1'b0;
endtask

task automatic store_word(input lc3b_word addr, input lc3b_word data);
	ldstr_issue_t ins;
	lc3b_word off;
	off = rand_offset();
	ins = '0;
	ins.opcode = op_str;
	ins.base = addr - off;
	ins.base_valid = 1'b1;
	ins.src = data;
	ins.src_valid = 1'b1;
	ins.offset = off;
	issue_op(ins);
	shadow[word_index(addr)] = data;
endtask

task automatic broadcast(input lc3b_tag tag, input lc3b_word value);
	cdb_in.valid = 1'b1;
	cdb_in.tag = tag;
	cdb_in.value = value;
	step();
	cdb_in.valid = 1'b0;
endtask

task automatic expect_load(input string name, input lc3b_tag tag, input lc3b_word value);
	int n;
	n = 0;
	while (!cdb_out.valid && n < LOAD_WAIT)
	begin
		step();
		n++;
	end
	assert (cdb_out.valid)
	else
	begin
		errors++;
		$display("%s: no load result on the CDB after %0d cycles", name, LOAD_WAIT);
	end
	if (cdb_out.valid)
	begin
		check_val(name, "tag", tag, cdb_out.tag);
		check_val(name, "value", value, cdb_out.value);
		ld_buffer_read = 1'b1;
		step();
		ld_buffer_read = 1'b0;
		check_val(name, "valid after read", 0, cdb_out.valid);
	end
endtask

// **********************************************************************
// Tests
// **********************************************************************

task automatic test_reset();
	repeat (5)
	begin
		check_val("reset", "full", 0, full);
		check_val("reset", "cdb_out valid", 0, cdb_out.valid);
		check_val("reset", "dmem_read", 0, u_ldstr_unit.dmem_read);
		check_val("reset", "dmem_write", 0, u_ldstr_unit.dmem_write);
		step();
	end
endtask

task automatic test_store_load();
	lc3b_word a;
	lc3b_word v;
	lc3b_word off;
	lc3b_tag t;
	a = rand_addr();
	v = lc3b_word'($random(seed));
	t = lc3b_tag'($random(seed));
	off = rand_offset();
	store_word(a, v);
	issue_op(make_load(t, a - off, 1'b1, '0, off));
	expect_load("store_load", t, v);
endtask

task automatic test_operand_wait();
	lc3b_word a;
	lc3b_word off;
	a = rand_addr();
	off = rand_offset();
	store_word(a, lc3b_word'($random(seed)));
	issue_op(make_load(3'd2, '0, 1'b0, 3'd6, off));
	repeat (10)
	begin
		check_val("operand_wait", "cdb_out valid before base", 0, cdb_out.valid);
		step();
	end
	broadcast(3'd6, a - off);
	expect_load("operand_wait", 3'd2, shadow[word_index(a)]);
endtask

task automatic test_ordering();
	int r;
	lc3b_word off;
	r = {$random(seed)} % `DMEM_WORDS;
	for (int k = 0; k < 4; k++)
	begin
		ord_addr[k] = lc3b_word'(((r + k * 61) % `DMEM_WORDS) * 2);
		store_word(ord_addr[k], lc3b_word'($random(seed)));
	end
	off = rand_offset();
	for (int k = 0; k < 4; k++)
		issue_op(make_load(lc3b_tag'(k + 1), ord_addr[k] - off, 1'b1, '0, off));
	for (int k = 0; k < 4; k++)
		expect_load("ordering", lc3b_tag'(k + 1), shadow[word_index(ord_addr[k])]);
endtask

task automatic test_full();
	lc3b_word addr [`LDSTR_DEPTH];
	lc3b_word off [`LDSTR_DEPTH];
	for (int k = 0; k < `LDSTR_DEPTH; k++)
	begin
		addr[k] = rand_addr();
		off[k] = rand_offset();
	end
	// Head load waits on tag 7 and blocks the rest
	issue_op(make_load(3'd0, '0, 1'b0, 3'd7, off[0]));
	for (int k = 1; k < `LDSTR_DEPTH; k++)
		issue_op(make_load(lc3b_tag'(k), addr[k] - off[k], 1'b1, '0, off[k]));
	check_val("full", "full after last issue", 1, full);
	broadcast(3'd7, addr[0] - off[0]);
	expect_load("full", 3'd0, shadow[word_index(addr[0])]);
	check_val("full", "full after one read", 0, full);
	for (int k = 1; k < `LDSTR_DEPTH; k++)
		expect_load("full", lc3b_tag'(k), shadow[word_index(addr[k])]);
endtask

task automatic test_flush();
	lc3b_word off;
	off = rand_offset();
	// Head load waits on tag 4 and the rest on tag 5
	issue_op(make_load(3'd0, '0, 1'b0, 3'd4, off));
	for (int k = 1; k < `LDSTR_DEPTH; k++)
		issue_op(make_load(lc3b_tag'(k), '0, 1'b0, 3'd5, off));
	check_val("flush", "full before flush", 1, full);
	broadcast(3'd4, ord_addr[0] - off);
	assert (u_ldstr_unit.dmem_read)
	else
	begin
		errors++;
		$display("flush: no memory access in flight when flush was raised");
	end
	flush = 1'b1;
	step();
	flush = 1'b0;
	for (int n = 0; n < QUIET_CYCLES; n++)
	begin
		check_val("flush", "full", 0, full);
		check_val("flush", "cdb_out valid", 0, cdb_out.valid);
		// Flushed entries must not wake on their old tag
		cdb_in.valid = (n == 5);
		cdb_in.tag = 3'd5;
		cdb_in.value = ord_addr[1];
		step();
	end
	cdb_in.valid = 1'b0;
	issue_op(make_load(3'd4, ord_addr[2] - off, 1'b1, '0, off));
	expect_load("flush", 3'd4, shadow[word_index(ord_addr[2])]);
endtask

initial
begin
	seed = 32'h6ea8;
	errors = 0;
	flush = 1'b0;
	we = 1'b0;
	issue = '0;
	ld_buffer_read = 1'b0;
	cdb_in = '0;
	for (int j = 0; j < `DMEM_WORDS; j++)
		shadow[j] = '0;
	wait (arst_n === 1'b1);
	test_reset();
	test_store_load();
	test_operand_wait();
	test_ordering();
	test_full();
	test_flush();
	$display("Run finished with %0d errors", errors);
	if (errors == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

initial
begin
	cycles = 0;
	while (cycles < CYCLE_LIMIT)
	begin
		@(posedge clk);
		cycles++;
	end
	$display("Timeout: run did not end within %0d cycles, %0d errors so far", CYCLE_LIMIT,
		errors);
	$display("=== FAIL ===");
	$finish;
end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic arst_n
);

// 40 ns period
initial
begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

initial
begin
	arst_n = 1'b0;
	repeat (3) @(posedge clk);
	#2 arst_n = 1'b1;
end

endmodule
